// File: sources.f
logic/wiscPkg.sv
logic/controlUnit.sv
logic/regFile.sv
logic/decode.sv
logic/executeUnit.sv
logic/programCounter.sv
logic/cycleSequencer.sv
logic/wiscCore.sv
sim/wiscCoreTb.sv

// File: Bender.yml
package:
  name: wisc_core

sources:
  - logic/wiscPkg.sv
  - logic/controlUnit.sv
  - logic/regFile.sv
  - logic/decode.sv
  - logic/executeUnit.sv
  - logic/programCounter.sv
  - logic/cycleSequencer.sv
  - logic/wiscCore.sv
  - target: simulation
    files:
      - sim/wiscCoreTb.sv

// File: sim/wiscCoreTb.sv
// testbench for wiscCore: clock, reset, memory slave, ISA model, two programs, assertions
module wiscCoreTb;
   timeunit 1ns;
   timeprecision 100ps;
   import wiscPkg::*;

   localparam logic [15:0] resetPc = 16'h0040;   // program starts at word 0x20

   logic        clk;
   logic        arstN;
   logic        wbCyc, wbStb, wbWe, wbAck, halted, err;
   logic [15:0] wbAdr, wbDatW, wbDatR;

   logic [15:0] mem    [256];   // bus memory
   logic [15:0] refMem [256];   // model's own copy
   logic [31:0] storeQ [$];     // expected stores as {adr, data}
   logic [19:0] lfsr;
   logic [15:0] expAdr, expDat;
   logic        expValid, expErr, firstFetch, busy, ok;
   logic [1:0]  delay;
   int          errors, storesSeen, expStores, totalStores, progPtr;

   wiscCore #(.resetPc(resetPc)) i_dut (
      .clk   (clk),
      .arstN (arstN),
      .wbCyc (wbCyc),
      .wbStb (wbStb),
      .wbWe  (wbWe),
      .wbAdr (wbAdr),
      .wbDatW(wbDatW),
      .wbDatR(wbDatR),
      .wbAck (wbAck),
      .halted(halted),
      .err   (err)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // fibonacci LFSR, x^20 + x^17 + 1
   function automatic logic [19:0] lfsrNext(input logic [19:0] s);
      return {s[18:0], s[19] ^ s[16]};
   endfunction

   function automatic logic [1:0] drawDelay();
      logic [1:0] d;
      d = '0;
      for (int i = 0; i < 2; i++) begin
         lfsr = lfsrNext(lfsr);   // one step per bit
         d    = {d[0], lfsr[0]};
      end
      return d;
   endfunction

   // wishbone slave, ack after 0..3 extra cycles, held for one cycle
   always @(posedge clk) begin
      if (!arstN) begin
         wbAck <= 1'b0;
         busy = 1'b0;
      end else if (wbAck) begin
         wbAck <= 1'b0;          // master drops stb this cycle
         busy = 1'b0;
      end else if (wbStb) begin
         if (!busy) begin
            busy  = 1'b1;
            delay = drawDelay();
         end
         if (delay == 2'd0) begin
            wbAck <= 1'b1;
            if (wbWe) mem[wbAdr[8:1]] <= wbDatW;
            else      wbDatR <= mem[wbAdr[8:1]];
         end else begin
            delay = delay - 2'd1;
         end
      end
   end

   // store tracking, front of the queue is the next expected write
   always @(posedge clk) begin
      if (!arstN) begin
         storesSeen <= 0;
      end else if (wbStb && wbWe && wbAck) begin
         storesSeen <= storesSeen + 1;
         if (storeQ.size() > 0) void'(storeQ.pop_front());
      end
      expValid <= storeQ.size() > 0;
      expAdr   <= (storeQ.size() > 0) ? storeQ[0][31:16] : 16'h0;
      expDat   <= (storeQ.size() > 0) ? storeQ[0][15:0] : 16'h0;
   end

   always @(posedge clk or negedge arstN) begin
      if (!arstN) firstFetch <= 1'b1;
      else if (wbStb) firstFetch <= 1'b0;
   end

   assert property (@(posedge clk) !arstN |-> !wbCyc && !wbStb && !wbWe && !halted && !err)
      else begin errors++; $display("bus strobes, halted or err active during reset"); end
   assert property (@(posedge clk)
         arstN && !$past(arstN) |-> !wbCyc && !wbStb && !wbWe && !halted && !err)
      else begin errors++; $display("outputs active in the first cycle after reset"); end
   assert property (@(posedge clk) disable iff (!arstN) firstFetch && wbStb |-> wbAdr == resetPc)
      else begin
         errors++;
         $display("[FAIL] wbAdr expected %h actual %h", resetPc, $sampled(wbAdr));
      end
   assert property (@(posedge clk) disable iff (!arstN) wbStb |-> wbCyc)
      else begin errors++; $display("wbStb high without wbCyc"); end
   assert property (@(posedge clk) disable iff (!arstN)
         wbStb && !wbAck |=> $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW))
      else begin errors++; $display("address, write enable or write data moved before ack"); end
   assert property (@(posedge clk) disable iff (!arstN) wbStb && wbAck |=> !wbStb)
      else begin errors++; $display("wbStb still high in the cycle after ack"); end
   assert property (@(posedge clk) disable iff (!arstN) wbStb && wbWe && wbAck |-> expValid)
      else begin errors++; $display("write cycle with no store left in the model"); end
   assert property (@(posedge clk) disable iff (!arstN)
         wbStb && wbWe && wbAck && expValid |-> wbAdr == expAdr)
      else begin
         errors++;
         $display("[FAIL] wbAdr expected %h actual %h", $sampled(expAdr), $sampled(wbAdr));
      end
   assert property (@(posedge clk) disable iff (!arstN)
         wbStb && wbWe && wbAck && expValid |-> wbDatW == expDat)
      else begin
         errors++;
         $display("[FAIL] wbDatW expected %h actual %h", $sampled(expDat), $sampled(wbDatW));
      end
   assert property (@(posedge clk) disable iff (!arstN) halted |-> !wbStb && !wbCyc)
      else begin errors++; $display("bus cycle started after the core stopped"); end
   assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
      else begin errors++; $display("core left the stopped state without reset"); end
   assert property (@(posedge clk) disable iff (!arstN) err |-> halted)
      else begin errors++; $display("err raised while the core still runs"); end

   function automatic logic [15:0] encI(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [2:0] rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] encR(input logic [1:0] func, input logic [2:0] rs,
                                        input logic [2:0] rt, input logic [2:0] rd);
      return {RARITH, rs, rt, rd, func};
   endfunction

   function automatic logic [15:0] encB(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [7:0] imm);
      return {op, rs, imm};   // BEQZ, BNEZ, LBI
   endfunction

   function automatic logic [15:0] encJ(input logic [4:0] op, input logic [10:0] disp);
      return {op, disp};
   endfunction

   task automatic emit(input logic [15:0] word);
      mem[progPtr] = word;
      progPtr++;
   endtask

   task automatic fillMem();
      for (int i = 0; i < 256; i++) begin
         mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0]};
      end
      progPtr = resetPc[8:1];
   endtask

   task automatic loadProgramA();
      fillMem();
      emit(encB(LBI, 1, 8'h80));        // r1 = ff80, data base
      emit(encB(LBI, 2, 8'h35));
      emit(encI(ADDI, 2, 3, 5'h1d));    // r2 - 3
      emit(encI(SUBI, 2, 4, 5'h07));    // 7 - r2
      emit(encI(XORI, 2, 5, 5'h1f));    // zero extended imm
      emit(encI(ANDNI, 4, 6, 5'h12));
      emit(encI(ST, 1, 3, 5'h00));
      emit(encI(ST, 1, 4, 5'h02));
      emit(encI(ST, 1, 5, 5'h04));
      emit(encI(ST, 1, 6, 5'h06));
      emit(encR(2'd0, 2, 4, 3));        // add
      emit(encR(2'd1, 2, 4, 4));        // sub, rt - rs
      emit(encR(2'd2, 5, 6, 5));        // xor
      emit(encR(2'd3, 4, 5, 6));        // andn
      emit(encI(ST, 1, 3, 5'h08));
      emit(encI(ST, 1, 4, 5'h0a));
      emit(encI(ST, 1, 5, 5'h0c));
      emit(encI(ST, 1, 6, 5'h0e));
      emit(encI(LD, 1, 7, 5'h02));      // reads an earlier store
      emit(encI(LD, 1, 0, 5'h10));      // offset -16, untouched fill word
      emit(encI(ST, 1, 7, 5'h1e));
      emit(encI(ST, 1, 0, 5'h1c));
      emit(encB(BEQZ, 2, 8'h02));       // not taken
      emit(encI(ST, 1, 2, 5'h1a));
      emit(encB(LBI, 0, 8'h00));
      emit(encB(BEQZ, 0, 8'h02));       // taken
      emit(encI(ST, 1, 0, 5'h18));      // skipped
      emit(encB(BNEZ, 2, 8'h02));       // taken
      emit(encI(ST, 1, 0, 5'h16));      // skipped
      emit(encJ(J, 11'h002));
      emit(encI(ST, 1, 0, 5'h14));      // skipped
      emit(encB(LBI, 3, 8'h03));        // loop count
      emit(encI(ST, 1, 3, 5'h12));      // loop body
      emit(encI(ADDI, 3, 3, 5'h1f));
      emit(encB(BNEZ, 3, 8'hfa));       // back to the body
      emit(encJ(NOP, 11'h000));
      emit(encJ(HALT, 11'h000));
   endtask

   task automatic loadProgramB();
      fillMem();
      emit(encB(LBI, 1, 8'h80));
      emit(encB(LBI, 2, 8'h11));
      emit(encI(ST, 1, 2, 5'h00));
      emit(encI(ADDI, 2, 2, 5'h01));
      emit(encI(ST, 1, 2, 5'h02));
      emit(encJ(5'b11111, 11'h000));    // not a WISC opcode
      emit(encI(ST, 1, 2, 5'h04));      // never reached
      emit(encJ(HALT, 11'h000));
   endtask

   // ISA model, fills the store queue and the expected err
   task automatic runModel();
      logic [15:0] r [8];
      logic [15:0] pc, ins, s5, z5, s8, s11, adr, res;
      logic [4:0]  op;
      logic [2:0]  rs, rt;
      logic        running;
      refMem = mem;
      storeQ.delete();
      r       = '{default: '0};
      pc      = resetPc;
      expErr  = 1'b0;
      running = 1'b1;
      for (int n = 0; n < 1000 && running; n++) begin
         ins = refMem[pc[8:1]];
         pc  = pc + 16'd2;       // branch targets are relative to the next word
         op  = ins[15:11];
         rs  = ins[10:8];
         rt  = ins[7:5];
         s5  = {{11{ins[4]}}, ins[4:0]};
         z5  = {11'b0, ins[4:0]};
         s8  = {{8{ins[7]}}, ins[7:0]};
         s11 = {{5{ins[10]}}, ins[10:0]};
         adr = r[rs] + s5;
         case (op)
            HALT:  running = 1'b0;
            NOP:   ;
            J:     pc = pc + s11;
            ADDI:  r[rt] = r[rs] + s5;
            SUBI:  r[rt] = s5 - r[rs];
            XORI:  r[rt] = r[rs] ^ z5;
            ANDNI: r[rt] = r[rs] & ~z5;
            BEQZ:  if (r[rs] == 16'h0) pc = pc + s8;
            BNEZ:  if (r[rs] != 16'h0) pc = pc + s8;
            ST: begin
               storeQ.push_back({adr, r[rt]});
               refMem[adr[8:1]] = r[rt];
            end
            LD:    r[rt] = refMem[adr[8:1]];
            LBI:   r[rs] = s8;
            RARITH: begin
               case (ins[1:0])
                  2'd0:    res = r[rs] + r[rt];
                  2'd1:    res = r[rt] - r[rs];
                  2'd2:    res = r[rs] ^ r[rt];
                  default: res = r[rs] & ~r[rt];
               endcase
               r[ins[4:2]] = res;
            end
            default: begin
               expErr  = 1'b1;       // illegal opcode stops the core
               running = 1'b0;
            end
         endcase
      end
      expStores = storeQ.size();
   endtask

   task automatic runProgram(input string name, output logic passed);
      logic seen;
      runModel();
      @(posedge clk);
      arstN <= 1'b0;
      repeat (4) @(posedge clk);
      arstN <= 1'b1;
      seen = 1'b0;
      for (int c = 0; c < 3000 && !seen; c++) begin
         @(negedge clk);
         seen = halted;
      end
      passed = seen;
      if (!seen) begin
         errors++;
         $display("%s: timed out waiting for halted", name);
         return;
      end
      assert (err == expErr)
         else begin errors++; $display("[FAIL] err expected %h actual %h", expErr, err); end
      repeat (20) @(posedge clk);   // quiet bus checked by the halted property
      @(negedge clk);
      assert (storesSeen == expStores)
         else begin
            errors++;
            $display("[FAIL] store count expected %h actual %h", expStores, storesSeen);
         end
      totalStores += storesSeen;
   endtask

   initial begin
      arstN       = 1'b1;   // pulled low on the first edge
      wbAck       = 1'b0;
      wbDatR      = 16'h0;
      busy        = 1'b0;
      delay       = 2'd0;
      lfsr        = 20'd98940;
      errors      = 0;
      totalStores = 0;
      loadProgramA();
      runProgram("program A", ok);
      if (ok) begin
         loadProgramB();
         runProgram("program B", ok);
      end
      $display("errors %0d, stores checked %0d", errors, totalStores);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: logic/wiscCore.sv
// top level wiring the multicycle core to its Wishbone master port
module wiscCore #(
   parameter logic [15:0] resetPc = 16'h0000
) (
   input  logic        clk,
   input  logic        arstN,
   output logic        wbCyc,
   output logic        wbStb,
   output logic        wbWe,
   output logic [15:0] wbAdr,
   output logic [15:0] wbDatW,
   input  logic [15:0] wbDatR,
   input  logic        wbAck,
   output logic        halted,
   output logic        err
);
   import wiscPkg::*;

   logic        irLoad, pcStep, pcLoad, aluLatch, memLatch, regWrtEn, adrSel;
   logic        memWrt, readEn, regWrt, halt, illegal;
   brchE        brchSig;
   aluOpE       aluOp;
   wbSelE       wbDataSel;
   logic [15:0] pc, inA, inB, imm8, brchOffset, wbData;

   cycleSequencer i_cycleSequencer (
      .clk     (clk),
      .arstN   (arstN),
      .wbAck   (wbAck),
      .memWrt  (memWrt),
      .readEn  (readEn),
      .regWrt  (regWrt),
      .brchSig (brchSig),
      .halt    (halt),
      .illegal (illegal),
      .wbCyc   (wbCyc),
      .wbStb   (wbStb),
      .wbWe    (wbWe),
      .irLoad  (irLoad),
      .pcStep  (pcStep),
      .pcLoad  (pcLoad),
      .aluLatch(aluLatch),
      .memLatch(memLatch),
      .regWrtEn(regWrtEn),
      .adrSel  (adrSel),
      .halted  (halted),
      .err     (err)
   );

   programCounter #(.resetPc(resetPc)) i_programCounter (
      .clk    (clk),
      .arstN  (arstN),
      .pcStep (pcStep),
      .pcLoad (pcLoad),
      .brchSig(brchSig),
      .rsValue(inA),          // branches test rs
      .offset (brchOffset),
      .pc     (pc)
   );

   decode i_decode (
      .clk       (clk),
      .arstN     (arstN),
      .irLoad    (irLoad),
      .instrIn   (wbDatR),
      .wbData    (wbData),
      .regWrtEn  (regWrtEn),
      .inA       (inA),
      .inB       (inB),
      .wrtData   (wbDatW),
      .imm8      (imm8),
      .brchOffset(brchOffset),
      .aluOp     (aluOp),
      .wbDataSel (wbDataSel),
      .memWrt    (memWrt),
      .readEn    (readEn),
      .regWrt    (regWrt),
      .brchSig   (brchSig),
      .halt      (halt),
      .illegal   (illegal)
   );

   executeUnit i_executeUnit (
      .clk      (clk),
      .arstN    (arstN),
      .inA      (inA),
      .inB      (inB),
      .aluOp    (aluOp),
      .aluLatch (aluLatch),
      .memLatch (memLatch),
      .wbDatR   (wbDatR),
      .wbDataSel(wbDataSel),
      .imm8     (imm8),
      .adrSel   (adrSel),
      .pc       (pc),
      .wbAdr    (wbAdr),
      .wbData   (wbData)
   );

endmodule

// File: logic/cycleSequencer.sv
// instruction state machine with Wishbone strobes and datapath step strobes
module cycleSequencer (
   input  logic          clk,
   input  logic          arstN,
   input  logic          wbAck,
   input  logic          memWrt,
   input  logic          readEn,
   input  logic          regWrt,
   input  wiscPkg::brchE brchSig,
   input  logic          halt,
   input  logic          illegal,
   output logic          wbCyc,
   output logic          wbStb,
   output logic          wbWe,
   output logic          irLoad,
   output logic          pcStep,
   output logic          pcLoad,
   output logic          aluLatch,
   output logic          memLatch,
   output logic          regWrtEn,
   output logic          adrSel,
   output logic          halted,
   output logic          err
);
   import wiscPkg::*;

   typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, WB, STOP} stateE;

   stateE state;
   stateE nextState;
   logic  done;       // bus transfer completes this cycle

   assign done = wbCyc && wbAck;

   always_comb begin
      nextState = state;
      case (state)
         FETCH:  if (done) nextState = DECODE;
         DECODE: nextState = (halt || illegal) ? STOP : EXEC;
         EXEC: begin
            if (memWrt || readEn) nextState = MEM;
            else if (regWrt)      nextState = WB;
            else                  nextState = FETCH;
         end
         MEM:    if (done) nextState = regWrt ? WB : FETCH;
         WB:     nextState = FETCH;
         default: nextState = STOP;   // held until reset
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= FETCH;
         wbCyc <= 1'b0;
         wbWe  <= 1'b0;
         err   <= 1'b0;
      end else begin
         state <= nextState;
         // request opens on entry to a bus state, drops for a cycle after each ack
         wbCyc <= (nextState == FETCH || nextState == MEM) && !done;
         wbWe  <= (nextState == MEM) && memWrt && !done;
         if (state == DECODE && illegal) err <= 1'b1;
      end
   end

   assign wbStb    = wbCyc;
   assign irLoad   = (state == FETCH) && done;
   assign pcStep   = irLoad;
   assign aluLatch = (state == EXEC);
   assign pcLoad   = (state == EXEC) && (brchSig != NONE);  // condition tested in the PC
   assign memLatch = (state == MEM) && done && readEn;
   assign regWrtEn = (state == WB);
   assign adrSel   = (state == MEM);
   assign halted   = (state == STOP);

endmodule

// File: logic/programCounter.sv
// program counter with increment, branch condition test and target load
module programCounter #(
   parameter logic [15:0] resetPc = 16'h0000
) (
   input  logic          clk,
   input  logic          arstN,
   input  logic          pcStep,
   input  logic          pcLoad,
   input  wiscPkg::brchE brchSig,
   input  logic [15:0]   rsValue,
   input  logic [15:0]   offset,
   output logic [15:0]   pc
);
   import wiscPkg::*;

   logic taken;

   always_comb begin
      case (brchSig)
         EQZ:     taken = (rsValue == '0);
         NEZ:     taken = (rsValue != '0);
         JUMP:    taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= resetPc;
      end else if (pcStep) begin
         pc <= pc + 16'd2;
      end else if (pcLoad && taken) begin
         pc <= pc + offset;     // pc already points past the branch
      end
   end

endmodule

// File: logic/executeUnit.sv
// ALU with result register, load data register, writeback and bus address selection
module executeUnit (
   input  logic           clk,
   input  logic           arstN,
   input  logic [15:0]    inA,
   input  logic [15:0]    inB,
   input  wiscPkg::aluOpE aluOp,
   input  logic           aluLatch,
   input  logic           memLatch,
   input  logic [15:0]    wbDatR,
   input  wiscPkg::wbSelE wbDataSel,
   input  logic [15:0]    imm8,
   input  logic           adrSel,
   input  logic [15:0]    pc,
   output logic [15:0]    wbAdr,
   output logic [15:0]    wbData
);
   import wiscPkg::*;

   logic [15:0] aluOut;
   logic [15:0] aluResult;
   logic [15:0] memData;

   always_comb begin
      case (aluOp)
         ADD:     aluOut = inA + inB;
         SUB:     aluOut = inB - inA;    // Rt - Rs, imm - Rs
         XOR:     aluOut = inA ^ inB;
         default: aluOut = inA & ~inB;   // ANDN
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         aluResult <= '0;
         memData   <= '0;
      end else begin
         if (aluLatch) aluResult <= aluOut;   // end of EXEC
         if (memLatch) memData   <= wbDatR;   // load ack
      end
   end

   always_comb begin
      case (wbDataSel)
         MEM:     wbData = memData;
         IMM8:    wbData = imm8;
         default: wbData = aluResult;
      endcase
   end

   assign wbAdr = adrSel ? aluResult : pc;   // data phase uses the computed address

endmodule

// File: logic/decode.sv
// decode stage with instruction register, immediates, register file and control unit
module decode (
   input  logic               clk,
   input  logic               arstN,
   input  logic               irLoad,
   input  logic [15:0]        instrIn,
   input  logic [15:0]        wbData,
   input  logic               regWrtEn,
   output logic [15:0]        inA,
   output logic [15:0]        inB,
   output logic [15:0]        wrtData,
   output logic [15:0]        imm8,
   output logic [15:0]        brchOffset,
   output wiscPkg::aluOpE     aluOp,
   output wiscPkg::wbSelE     wbDataSel,
   output logic               memWrt,
   output logic               readEn,
   output logic               regWrt,
   output wiscPkg::brchE      brchSig,
   output logic               halt,
   output logic               illegal
);
   import wiscPkg::*;

   instrWordU   instr;
   logic [15:0] imm5;
   logic [15:0] jDisp;
   logic [15:0] read2Data;
   logic [2:0]  writeSel;
   logic        bSrc;
   logic        zeroSel;
   logic [1:0]  regDestSel;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         instr <= '0;
      end else if (irLoad) begin
         instr <= instrIn;      // taken on the fetch ack
      end
   end

   assign imm5  = zeroSel ? {11'b0, instr.iFmt.imm5}
                          : {{11{instr.iFmt.imm5[4]}}, instr.iFmt.imm5};
   assign imm8  = {{8{instr.jFmt.disp[7]}}, instr.jFmt.disp[7:0]};
   assign jDisp = {{5{instr.jFmt.disp[10]}}, instr.jFmt.disp};

   assign brchOffset = (brchSig == JUMP) ? jDisp : imm8;

   always_comb begin
      case (regDestSel)
         2'd0:    writeSel = instr.rFmt.rd;
         2'd2:    writeSel = instr.iFmt.rs;   // LBI
         default: writeSel = instr.iFmt.rd;
      endcase
   end

   // read port 2 sits on bits 7:5, rt for R-format and the store register for ST
   regFile i_regFile (
      .clk      (clk),
      .arstN    (arstN),
      .read1Sel (instr.rFmt.rs),
      .read2Sel (instr.rFmt.rt),
      .read1Data(inA),
      .read2Data(read2Data),
      .writeSel (writeSel),
      .writeData(wbData),
      .writeEn  (regWrtEn)
   );

   assign inB     = bSrc ? imm5 : read2Data;
   assign wrtData = read2Data;              // ST data

   controlUnit i_controlUnit (
      .instruction(instr),
      .aluOp      (aluOp),
      .bSrc       (bSrc),
      .zeroSel    (zeroSel),
      .regDestSel (regDestSel),
      .wbDataSel  (wbDataSel),
      .memWrt     (memWrt),
      .readEn     (readEn),
      .regWrt     (regWrt),
      .brchSig    (brchSig),
      .halt       (halt),
      .illegal    (illegal)
   );

endmodule

// File: logic/regFile.sv
// eight 16-bit registers, two asynchronous read ports, one synchronous write port
module regFile (
   input  logic        clk,
   input  logic        arstN,
   input  logic [2:0]  read1Sel,
   input  logic [2:0]  read2Sel,
   output logic [15:0] read1Data,
   output logic [15:0] read2Data,
   input  logic [2:0]  writeSel,
   input  logic [15:0] writeData,
   input  logic        writeEn
);

   logic [15:0] regs [8];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         regs <= '{default: '0};
      end else if (writeEn) begin
         regs[writeSel] <= writeData;
      end
   end

   // no bypass, the sequencer never reads and writes in the same cycle
   assign read1Data = regs[read1Sel];
   assign read2Data = regs[read2Sel];

endmodule

// File: logic/controlUnit.sv
// combinational opcode decoder producing the datapath controls and the illegal flag
module controlUnit (
   input  wiscPkg::instrWordU instruction,
   output wiscPkg::aluOpE     aluOp,
   output logic               bSrc,        // 1 selects imm5 for ALU B
   output logic               zeroSel,     // 1 zero-extends imm5
   output logic [1:0]         regDestSel,  // 0 R rd, 1 I rd, 2 rs
   output wiscPkg::wbSelE     wbDataSel,
   output logic               memWrt,
   output logic               readEn,
   output logic               regWrt,
   output wiscPkg::brchE      brchSig,
   output logic               halt,
   output logic               illegal
);
   import wiscPkg::*;

   always_comb begin
      // defaults describe a NOP
      aluOp      = ADD;
      bSrc       = 1'b0;
      zeroSel    = 1'b0;
      regDestSel = 2'd1;
      wbDataSel  = ALU;
      memWrt     = 1'b0;
      readEn     = 1'b0;
      regWrt     = 1'b0;
      brchSig    = NONE;
      halt       = 1'b0;
      illegal    = 1'b0;
      case (instruction.rFmt.opcode)
         HALT: halt = 1'b1;
         NOP:  ;
         J:    brchSig = JUMP;
         ADDI, SUBI, XORI, ANDNI: begin
            aluOp   = aluOpE'(instruction.iFmt.opcode[1:0]);  // low bits map to op
            bSrc    = 1'b1;
            zeroSel = instruction.iFmt.opcode[1];             // XORI, ANDNI
            regWrt  = 1'b1;
         end
         BEQZ: brchSig = EQZ;
         BNEZ: brchSig = NEZ;
         ST: begin
            bSrc   = 1'b1;    // address = rs + imm5
            memWrt = 1'b1;
         end
         LD: begin
            bSrc      = 1'b1;
            readEn    = 1'b1;
            regWrt    = 1'b1;
            wbDataSel = MEM;
         end
         LBI: begin
            regWrt     = 1'b1;
            regDestSel = 2'd2;   // LBI writes its rs field
            wbDataSel  = IMM8;
         end
         RARITH: begin
            aluOp      = aluOpE'(instruction.rFmt.func);
            regWrt     = 1'b1;
            regDestSel = 2'd0;
         end
         default: illegal = 1'b1;
      endcase
   end

endmodule

// File: logic/wiscPkg.sv
// opcodes, ALU operations, writeback and branch selects, instruction word views
package wiscPkg;

   // supported opcodes, anything else decodes as illegal
   typedef enum logic [4:0] {
      HALT   = 5'b00000,
      NOP    = 5'b00001,
      J      = 5'b00100,
      ADDI   = 5'b01000,
      SUBI   = 5'b01001,
      XORI   = 5'b01010,
      ANDNI  = 5'b01011,
      BEQZ   = 5'b01100,
      BNEZ   = 5'b01101,
      ST     = 5'b10000,
      LD     = 5'b10001,
      LBI    = 5'b11000,
      RARITH = 5'b11011       // ADD/SUB/XOR/ANDN picked by func
   } opcodeE;

   // same order as the R-format func field and the low opcode bits of the I group
   typedef enum logic [1:0] {ADD, SUB, XOR, ANDN} aluOpE;

   typedef enum logic [1:0] {ALU, MEM, IMM8} wbSelE;   // register writeback source

   typedef enum logic [1:0] {NONE, EQZ, NEZ, JUMP} brchE;

   typedef struct packed {
      opcodeE     opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } rFmtS;

   typedef struct packed {
      opcodeE     opcode;
      logic [2:0] rs;
      logic [2:0] rd;         // also the store data register
      logic [4:0] imm5;
   } iFmtS;

   typedef struct packed {
      opcodeE      opcode;
      logic [10:0] disp;      // low byte doubles as imm8 for BEQZ/BNEZ/LBI
   } jFmtS;

   // one 16-bit word, three decodings
   typedef union packed {
      rFmtS rFmt;
      iFmtS iFmt;
      jFmtS jFmt;
   } instrWordU;

endpackage
